/* common/core_cfg_pkg.sv */
package core_cfg_pkg;

    // datapath and address width
    localparam int xlen_c = 64;

    localparam int inst_w_c = 32;

    // x0..x31
    localparam int reg_addr_w_c = 5;

    localparam logic [xlen_c-1:0] reset_pc_c = '0;

    // addi x0, x0, 0 serves as the pipeline bubble
    localparam logic [inst_w_c-1:0] nop_inst_c = 32'h0000_0013;

endpackage

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        STORE  = 7'b0100011
    } opcode_e;

    // funct3 of register and immediate arithmetic
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001
    } br_f3_e;

    // doubleword store only
    typedef enum logic [2:0] {
        F3_SD = 3'b011
    } st_f3_e;

    localparam logic [6:0] f7_base_c = 7'b0000000;
    localparam logic [6:0] f7_sub_c  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // how execute resolves the instruction
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } br_kind_e;

endpackage

/* fetch/inst_fetch.sv */
module inst_fetch (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                jump_en_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]     jump_addr_i,
    input  logic [core_cfg_pkg::inst_w_c-1:0]   if_inst_i,
    output logic [core_cfg_pkg::xlen_c-1:0]     if_inst_addr_o,
    output logic [core_cfg_pkg::inst_w_c-1:0]   id_inst_o,
    output logic [core_cfg_pkg::xlen_c-1:0]     id_pc_o
);
    import core_cfg_pkg::*;

    logic [xlen_c-1:0] pc_q;

    // instruction port is combinational, word comes back this cycle
    assign if_inst_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= reset_pc_c;
        end else if (jump_en_i) begin
            pc_q <= jump_addr_i;
        end else begin
            pc_q <= pc_q + xlen_c'(4);
        end
    end

    // wrong-path word is dropped on a taken jump
    always_ff @(posedge clk) begin
        if (!rst_n_i || jump_en_i) begin
            id_inst_o <= nop_inst_c;
        end else begin
            id_inst_o <= if_inst_i;
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o <= pc_q;
    end

    // targets come from execute, so alignment depends on decode immediates
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i) pc_q[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc_q);

endmodule

/* decode/inst_decode.sv */
module inst_decode (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    flush_i,
    input  logic [core_cfg_pkg::inst_w_c-1:0]       inst_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         pc_i,
    output logic [core_cfg_pkg::reg_addr_w_c-1:0]   rs1_addr_o,
    output logic [core_cfg_pkg::reg_addr_w_c-1:0]   rs2_addr_o,
    input  logic [core_cfg_pkg::xlen_c-1:0]         rs1_data_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         rs2_data_i,
    output logic [core_cfg_pkg::xlen_c-1:0]         ex_pc_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         ex_op1_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         ex_op2_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         ex_imm_o,
    output rv_isa_pkg::alu_op_e                     ex_alu_op_o,
    output rv_isa_pkg::br_kind_e                    ex_br_kind_o,
    output logic [core_cfg_pkg::reg_addr_w_c-1:0]   ex_rd_addr_o,
    output logic                                    ex_reg_wen_o,
    output logic                                    ex_store_o
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [reg_addr_w_c-1:0] rd_addr;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [xlen_c-1:0]       imm_i_ext;
    logic [xlen_c-1:0]       imm_s_ext;
    logic [xlen_c-1:0]       imm_b_ext;
    logic [xlen_c-1:0]       imm_j_ext;
    logic [xlen_c-1:0]       imm;
    logic [xlen_c-1:0]       op2;
    alu_op_e                 alu_op;
    br_kind_e                br_kind;
    logic                    reg_wen;
    logic                    store;

    assign rd_addr    = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign funct7     = inst_i[31:25];

    assign imm_i_ext = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_ext = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_ext = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_j_ext = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    // anything not matched below leaves the bubble defaults
    always_comb begin
        alu_op  = ALU_ADD;
        br_kind = BR_NONE;
        imm     = imm_i_ext;
        op2     = rs2_data_i;
        reg_wen = 1'b0;
        store   = 1'b0;
        case (inst_i[6:0])
            OP: begin
                reg_wen = (funct7 == f7_base_c) ||
                          (funct7 == f7_sub_c && funct3 == F3_ADD_SUB);
                case (funct3)
                    F3_ADD_SUB: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    reg_wen = 1'b0;
                endcase
            end
            OP_IMM: begin
                // addi only, immediate takes the op2 slot
                reg_wen = (funct3 == F3_ADD_SUB);
                op2     = imm_i_ext;
            end
            BRANCH: begin
                imm = imm_b_ext;
                if (funct3 == F3_BEQ) begin
                    br_kind = BR_EQ;
                end else if (funct3 == F3_BNE) begin
                    br_kind = BR_NE;
                end
            end
            JAL: begin
                imm     = imm_j_ext;
                br_kind = BR_JUMP;
                reg_wen = 1'b1;
            end
            STORE: begin
                imm   = imm_s_ext;
                store = (funct3 == F3_SD);
            end
            default: ;
        endcase
        // x0 is never written
        if (rd_addr == '0) begin
            reg_wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex_reg_wen_o <= 1'b0;
            ex_store_o   <= 1'b0;
            ex_br_kind_o <= BR_NONE;
        end else begin
            ex_reg_wen_o <= reg_wen;
            ex_store_o   <= store;
            ex_br_kind_o <= br_kind;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o      <= pc_i;
        ex_op1_o     <= rs1_data_i;
        ex_op2_o     <= op2;
        ex_imm_o     <= imm;
        ex_alu_op_o  <= alu_op;
        ex_rd_addr_o <= rd_addr;
    end

    store_no_wen: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_store_o |-> !ex_reg_wen_o)
        else $error("store in execute with register write set");

endmodule

/* verilog/reg_bypass.sv */
module reg_bypass (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   rs1_addr_i,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   rs2_addr_i,
    output logic [core_cfg_pkg::xlen_c-1:0]         rs1_data_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         rs2_data_o,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   ex_rd_addr_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         ex_rd_data_i,
    input  logic                                    ex_reg_wen_i,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   mem_rd_addr_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         mem_rd_data_i,
    input  logic                                    mem_reg_wen_i,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   wb_rd_addr_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         wb_rd_data_i,
    input  logic                                    wb_reg_wen_i
);
    import core_cfg_pkg::*;

    // x0 has no storage
    logic [xlen_c-1:0] regs_q [31:1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_reg_wen_i) begin
            regs_q[wb_rd_addr_i] <= wb_rd_data_i;
        end
    end

    // youngest producer wins
    function automatic logic [xlen_c-1:0] read_port(input logic [reg_addr_w_c-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (ex_reg_wen_i && ex_rd_addr_i == addr) begin
            return ex_rd_data_i;
        end else if (mem_reg_wen_i && mem_rd_addr_i == addr) begin
            return mem_rd_data_i;
        end else if (wb_reg_wen_i && wb_rd_addr_i == addr) begin
            return wb_rd_data_i;
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // decode is what keeps rd == 0 from enabling a write
    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_reg_wen_i |-> wb_rd_addr_i != '0)
        else $error("register write targets x0");

endmodule

/* execute/execute.sv */
module execute (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         pc_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         op1_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         op2_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         imm_i,
    input  rv_isa_pkg::alu_op_e                     alu_op_i,
    input  rv_isa_pkg::br_kind_e                    br_kind_i,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   rd_addr_i,
    input  logic                                    reg_wen_i,
    input  logic                                    store_i,
    output logic                                    jump_en_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         jump_addr_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         rd_data_o,
    output logic [core_cfg_pkg::reg_addr_w_c-1:0]   rd_addr_o,
    output logic                                    reg_wen_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         mem_rd_data_o,
    output logic [core_cfg_pkg::reg_addr_w_c-1:0]   mem_rd_addr_o,
    output logic                                    mem_reg_wen_o,
    output logic                                    mem_store_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         mem_waddr_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         mem_wdata_o
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [xlen_c-1:0] alu_res;

    // op2 already carries the immediate for addi
    always_comb begin
        case (alu_op_i)
            ALU_SUB: alu_res = op1_i - op2_i;
            ALU_AND: alu_res = op1_i & op2_i;
            ALU_OR:  alu_res = op1_i | op2_i;
            ALU_XOR: alu_res = op1_i ^ op2_i;
            default: alu_res = op1_i + op2_i;
        endcase
    end

    always_comb begin
        case (br_kind_i)
            BR_EQ:   jump_en_o = (op1_i == op2_i);
            BR_NE:   jump_en_o = (op1_i != op2_i);
            BR_JUMP: jump_en_o = 1'b1;
            default: jump_en_o = 1'b0;
        endcase
    end

    assign jump_addr_o = pc_i + imm_i;

    // jal links pc + 4
    assign rd_data_o = (br_kind_i == BR_JUMP) ? pc_i + xlen_c'(4) : alu_res;
    assign rd_addr_o = rd_addr_i;
    assign reg_wen_o = reg_wen_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_reg_wen_o <= 1'b0;
            mem_store_o   <= 1'b0;
        end else begin
            mem_reg_wen_o <= reg_wen_i;
            mem_store_o   <= store_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd_data_o <= rd_data_o;
        mem_rd_addr_o <= rd_addr_i;
        mem_waddr_o   <= op1_i + imm_i;
        mem_wdata_o   <= op2_i;
    end

    // decode flush must turn the following slot into a bubble
    jump_then_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        jump_en_o |=> !jump_en_o)
        else $error("back-to-back jumps, flush did not take effect");

endmodule

/* verilog/mem_wb.sv */
module mem_wb (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    store_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         waddr_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         wdata_i,
    input  logic [core_cfg_pkg::xlen_c-1:0]         rd_data_i,
    input  logic [core_cfg_pkg::reg_addr_w_c-1:0]   rd_addr_i,
    input  logic                                    reg_wen_i,
    output logic                                    mem_wen_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         mem_waddr_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         mem_wdata_o,
    output logic [core_cfg_pkg::xlen_c-1:0]         wb_rd_data_o,
    output logic [core_cfg_pkg::reg_addr_w_c-1:0]   wb_rd_addr_o,
    output logic                                    wb_reg_wen_o
);

    // store port comes straight from the execute/memory register
    assign mem_wen_o   = store_i;
    assign mem_waddr_o = waddr_i;
    assign mem_wdata_o = wdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_reg_wen_o <= 1'b0;
        end else begin
            wb_reg_wen_o <= reg_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_data_o <= rd_data_i;
        wb_rd_addr_o <= rd_addr_i;
    end

    sd_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        store_i |-> waddr_i[2:0] == 3'b000)
        else $error("misaligned doubleword store at %h", waddr_i);

endmodule

/* verilog/core.sv */
module core (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [core_cfg_pkg::inst_w_c-1:0]   if_inst_i,
    output logic [core_cfg_pkg::xlen_c-1:0]     if_inst_addr_o,
    output logic                                mem_wen_o,
    output logic [core_cfg_pkg::xlen_c-1:0]     mem_waddr_o,
    output logic [core_cfg_pkg::xlen_c-1:0]     mem_wdata_o
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // fetch to decode
    logic [inst_w_c-1:0]     id_inst;
    logic [xlen_c-1:0]       id_pc;

    // decode and register read
    logic [reg_addr_w_c-1:0] rs1_addr;
    logic [reg_addr_w_c-1:0] rs2_addr;
    logic [xlen_c-1:0]       rs1_data;
    logic [xlen_c-1:0]       rs2_data;

    // decode/execute register
    logic [xlen_c-1:0]       ex_pc;
    logic [xlen_c-1:0]       ex_op1;
    logic [xlen_c-1:0]       ex_op2;
    logic [xlen_c-1:0]       ex_imm;
    alu_op_e                 ex_alu_op;
    br_kind_e                ex_br_kind;
    logic [reg_addr_w_c-1:0] ex_rd_addr;
    logic                    ex_reg_wen;
    logic                    ex_store;

    // redirect and execute forwarding
    logic                    jump_en;
    logic [xlen_c-1:0]       jump_addr;
    logic [xlen_c-1:0]       fwd_rd_data;
    logic [reg_addr_w_c-1:0] fwd_rd_addr;
    logic                    fwd_reg_wen;

    // execute/memory register
    logic [xlen_c-1:0]       mem_rd_data;
    logic [reg_addr_w_c-1:0] mem_rd_addr;
    logic                    mem_reg_wen;
    logic                    mem_store;
    logic [xlen_c-1:0]       mem_st_addr;
    logic [xlen_c-1:0]       mem_st_data;

    // writeback
    logic [xlen_c-1:0]       wb_rd_data;
    logic [reg_addr_w_c-1:0] wb_rd_addr;
    logic                    wb_reg_wen;

    inst_fetch inst_fetch_inst (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .jump_en_i      ( jump_en        ),
        .jump_addr_i    ( jump_addr      ),
        .if_inst_i      ( if_inst_i      ),
        .if_inst_addr_o ( if_inst_addr_o ),
        .id_inst_o      ( id_inst        ),
        .id_pc_o        ( id_pc          )
    );

    inst_decode inst_decode_inst (
        .clk          ( clk        ),
        .rst_n_i      ( rst_n_i    ),
        .flush_i      ( jump_en    ),
        .inst_i       ( id_inst    ),
        .pc_i         ( id_pc      ),
        .rs1_addr_o   ( rs1_addr   ),
        .rs2_addr_o   ( rs2_addr   ),
        .rs1_data_i   ( rs1_data   ),
        .rs2_data_i   ( rs2_data   ),
        .ex_pc_o      ( ex_pc      ),
        .ex_op1_o     ( ex_op1     ),
        .ex_op2_o     ( ex_op2     ),
        .ex_imm_o     ( ex_imm     ),
        .ex_alu_op_o  ( ex_alu_op  ),
        .ex_br_kind_o ( ex_br_kind ),
        .ex_rd_addr_o ( ex_rd_addr ),
        .ex_reg_wen_o ( ex_reg_wen ),
        .ex_store_o   ( ex_store   )
    );

    reg_bypass reg_bypass_inst (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n_i     ),
        .rs1_addr_i    ( rs1_addr    ),
        .rs2_addr_i    ( rs2_addr    ),
        .rs1_data_o    ( rs1_data    ),
        .rs2_data_o    ( rs2_data    ),
        .ex_rd_addr_i  ( fwd_rd_addr ),
        .ex_rd_data_i  ( fwd_rd_data ),
        .ex_reg_wen_i  ( fwd_reg_wen ),
        .mem_rd_addr_i ( mem_rd_addr ),
        .mem_rd_data_i ( mem_rd_data ),
        .mem_reg_wen_i ( mem_reg_wen ),
        .wb_rd_addr_i  ( wb_rd_addr  ),
        .wb_rd_data_i  ( wb_rd_data  ),
        .wb_reg_wen_i  ( wb_reg_wen  )
    );

    execute execute_inst (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n_i     ),
        .pc_i          ( ex_pc       ),
        .op1_i         ( ex_op1      ),
        .op2_i         ( ex_op2      ),
        .imm_i         ( ex_imm      ),
        .alu_op_i      ( ex_alu_op   ),
        .br_kind_i     ( ex_br_kind  ),
        .rd_addr_i     ( ex_rd_addr  ),
        .reg_wen_i     ( ex_reg_wen  ),
        .store_i       ( ex_store    ),
        .jump_en_o     ( jump_en     ),
        .jump_addr_o   ( jump_addr   ),
        .rd_data_o     ( fwd_rd_data ),
        .rd_addr_o     ( fwd_rd_addr ),
        .reg_wen_o     ( fwd_reg_wen ),
        .mem_rd_data_o ( mem_rd_data ),
        .mem_rd_addr_o ( mem_rd_addr ),
        .mem_reg_wen_o ( mem_reg_wen ),
        .mem_store_o   ( mem_store   ),
        .mem_waddr_o   ( mem_st_addr ),
        .mem_wdata_o   ( mem_st_data )
    );

    mem_wb mem_wb_inst (
        .clk          ( clk         ),
        .rst_n_i      ( rst_n_i     ),
        .store_i      ( mem_store   ),
        .waddr_i      ( mem_st_addr ),
        .wdata_i      ( mem_st_data ),
        .rd_data_i    ( mem_rd_data ),
        .rd_addr_i    ( mem_rd_addr ),
        .reg_wen_i    ( mem_reg_wen ),
        .mem_wen_o    ( mem_wen_o   ),
        .mem_waddr_o  ( mem_waddr_o ),
        .mem_wdata_o  ( mem_wdata_o ),
        .wb_rd_data_o ( wb_rd_data  ),
        .wb_rd_addr_o ( wb_rd_addr  ),
        .wb_reg_wen_o ( wb_reg_wen  )
    );

endmodule

/* verification/core_tb.sv */
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int max_st_c    = 64;
    localparam int max_steps_c = 1000;
    localparam int timeout_c   = 2000;

    logic                clk;
    logic                rst_n;
    logic [inst_w_c-1:0] if_inst;
    logic [xlen_c-1:0]   if_inst_addr;
    logic                mem_wen;
    logic [xlen_c-1:0]   mem_waddr;
    logic [xlen_c-1:0]   mem_wdata;

    logic [inst_w_c-1:0] rom [0:63];
    int                  prog_len = 0;
    logic [xlen_c-1:0]   exp_addr [0:max_st_c-1];
    logic [xlen_c-1:0]   exp_data [0:max_st_c-1];
    logic [xlen_c-1:0]   act_addr [0:max_st_c-1];
    logic [xlen_c-1:0]   act_data [0:max_st_c-1];
    int                  act_cnt  = 0;
    int                  wen_errs = 0;
    int                  errors   = 0;
    int                  checks   = 0;
    int                  tests    = 0;
    int                  seed     = 96567;
    logic                rst_prev = 1'b1;

    core uut (
        .clk            ( clk          ),
        .rst_n_i        ( rst_n        ),
        .if_inst_i      ( if_inst      ),
        .if_inst_addr_o ( if_inst_addr ),
        .mem_wen_o      ( mem_wen      ),
        .mem_waddr_o    ( mem_waddr    ),
        .mem_wdata_o    ( mem_wdata    )
    );

    always #5 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] alu_r(input logic [2:0] f3, input logic [6:0] f7,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], 5'(rs1), 3'b000, 5'(rd), OP_IMM};
    endfunction

    function automatic logic [31:0] sd(input int rs2, input int rs1, input int imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b011, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] br(input logic [2:0] f3, input int rs1, input int rs2,
                                       input int imm);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] jal_w(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), JAL};
    endfunction

    // past the program, every fetch spins on a jump to itself
    always_comb begin
        if (if_inst_addr < 64'(prog_len) * 4) begin
            if_inst = rom[if_inst_addr[7:2]];
        end else begin
            if_inst = jal_w(0, 0);
        end
    end

    // store recorder, also watches the port while reset is held
    always @(posedge clk) begin
        if (!rst_n) begin
            act_cnt <= 0;
            if (!rst_prev && mem_wen !== 1'b0) begin
                $display("mem_wen_o not low during reset at %0t", $time);
                wen_errs <= wen_errs + 1;
            end
        end else if (mem_wen === 1'b1) begin
            if (act_cnt < max_st_c) begin
                act_addr[act_cnt] <= mem_waddr;
                act_data[act_cnt] <= mem_wdata;
            end
            act_cnt <= act_cnt + 1;
        end
        rst_prev <= rst_n;
    end

    // sequential ISA model, returns the number of stores
    function automatic int ref_run(input int n_words);
        logic [xlen_c-1:0] x [0:31];
        logic [xlen_c-1:0] pc;
        logic [xlen_c-1:0] nxt;
        logic [xlen_c-1:0] res;
        logic [xlen_c-1:0] a;
        logic [xlen_c-1:0] b;
        logic [31:0]       w;
        logic              wr;
        logic              taken;
        int                cnt;
        int                steps;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = '0;
        cnt = 0;
        steps = 0;
        while (steps < max_steps_c && pc < 64'(n_words) * 4) begin
            w = rom[pc[7:2]];
            a = x[w[19:15]];
            b = x[w[24:20]];
            nxt = pc + 4;
            wr = 1'b0;
            res = '0;
            steps++;
            case (w[6:0])
                OP: begin
                    wr = 1'b1;
                    case (w[14:12])
                        3'b000:  res = w[30] ? a - b : a + b;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                OP_IMM: begin
                    wr = 1'b1;
                    res = a + {{52{w[31]}}, w[31:20]};
                end
                BRANCH: begin
                    taken = (w[14:12] == 3'b000) ? (a == b) : (a != b);
                    if (taken) begin
                        nxt = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                JAL: begin
                    wr = 1'b1;
                    res = pc + 4;
                    nxt = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                STORE: begin
                    if (cnt < max_st_c) begin
                        exp_addr[cnt] = a + {{52{w[31]}}, w[31:25], w[11:7]};
                        exp_data[cnt] = b;
                    end
                    cnt++;
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = res;
            end
            pc = nxt;
        end
        return cnt;
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic reset_on();
        @(posedge clk);
        rst_n <= 1'b0;
    endtask

    task automatic reset_off();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_stores(input int n, output bit done);
        int cyc;
        cyc = 0;
        while (act_cnt < n && cyc < timeout_c) begin
            @(posedge clk);
            cyc++;
        end
        done = (act_cnt >= n);
    endtask

    task automatic check_run(input string name);
        int n;
        int errs0;
        bit done;
        errs0 = errors + wen_errs;
        n = ref_run(prog_len);
        wait_stores(n, done);
        if (!done) begin
            $display("%s: timed out with %0d of %0d stores", name, act_cnt, n);
            errors++;
        end else begin
            for (int i = 0; i < n; i++) begin
                checks++;
                if (act_addr[i] !== exp_addr[i] || act_data[i] !== exp_data[i]) begin
                    $display("FAIL %s store %0d: expected %h/%h, actual %h/%h", name, i,
                             exp_addr[i], exp_data[i], act_addr[i], act_data[i]);
                    errors++;
                end
            end
            repeat (20) @(posedge clk);
            if (act_cnt != n) begin
                $display("%s: %0d stores seen where %0d were expected", name, act_cnt, n);
                errors++;
            end
        end
        tests++;
        $display("test %s finished, %0d stores, %0d errors", name, n,
                 errors + wen_errs - errs0);
    endtask

    task automatic load_random();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int imm;
        prog_len = 0;
        for (int i = 0; i < 40; i++) begin
            kind = {$random(seed)} % 9;
            rd   = {$random(seed)} % 8;
            rs1  = {$random(seed)} % 8;
            rs2  = {$random(seed)} % 8;
            imm  = $random(seed);
            case (kind)
                0, 1: emit(addi(rd, rs1, imm));
                2: emit(alu_r(F3_ADD_SUB, f7_base_c, rd, rs1, rs2));
                3: emit(alu_r(F3_ADD_SUB, f7_sub_c, rd, rs1, rs2));
                4: emit(alu_r(F3_XOR, f7_base_c, rd, rs1, rs2));
                5: emit(alu_r(F3_OR, f7_base_c, rd, rs1, rs2));
                6: emit(alu_r(F3_AND, f7_base_c, rd, rs1, rs2));
                // x0 base keeps every doubleword address aligned
                default: emit(sd(rs2, 0, imm & 32'hff8));
            endcase
        end
    endtask

    initial begin
        bit done;
        clk = 1'b0;
        rst_n = 1'b0;

        // dependent chain, forwarding from every stage
        reset_on();
        prog_len = 0;
        emit(addi(1, 0, 5));
        emit(addi(2, 1, 7));
        emit(alu_r(F3_ADD_SUB, f7_base_c, 3, 2, 1));
        emit(alu_r(F3_ADD_SUB, f7_sub_c, 4, 3, 1));
        emit(alu_r(F3_XOR, f7_base_c, 5, 4, 2));
        emit(alu_r(F3_OR, f7_base_c, 6, 5, 3));
        emit(alu_r(F3_AND, f7_base_c, 7, 6, 5));
        emit(sd(7, 0, 0));
        emit(sd(6, 0, 8));
        emit(alu_r(F3_ADD_SUB, f7_base_c, 8, 7, 4));
        emit(sd(8, 0, 16));
        emit(addi(9, 8, 100));
        emit(sd(9, 0, 24));
        reset_off();
        check_run("alu_chain");

        // negative immediates and x0
        reset_on();
        prog_len = 0;
        emit(addi(1, 0, -1));
        emit(addi(2, 1, -2048));
        emit(addi(0, 1, 5));
        emit(sd(0, 0, 0));
        emit(alu_r(F3_ADD_SUB, f7_base_c, 3, 0, 1));
        emit(sd(3, 0, 8));
        emit(sd(2, 0, -8));
        emit(addi(4, 2, 2047));
        emit(sd(4, 0, 16));
        reset_off();
        check_run("imm_x0");

        // taken and not-taken branches, shadow stores must vanish
        reset_on();
        prog_len = 0;
        emit(addi(1, 0, 3));
        emit(addi(2, 0, 3));
        emit(br(F3_BEQ, 1, 2, 12));
        emit(sd(1, 0, 0));
        emit(sd(2, 0, 8));
        emit(br(F3_BNE, 1, 2, 12));
        emit(sd(1, 0, 16));
        emit(addi(2, 2, 1));
        emit(br(F3_BNE, 1, 2, 12));
        emit(sd(1, 0, 24));
        emit(sd(2, 0, 32));
        emit(br(F3_BEQ, 1, 2, 8));
        emit(sd(2, 0, 40));
        emit(br(F3_BEQ, 0, 0, 12));
        emit(sd(1, 0, 48));
        emit(sd(1, 0, 56));
        emit(sd(1, 0, 64));
        reset_off();
        check_run("branch");

        // jal link value and skipped code
        reset_on();
        prog_len = 0;
        emit(addi(1, 0, 9));
        emit(jal_w(5, 16));
        emit(sd(1, 0, 0));
        emit(addi(1, 0, 1));
        emit(sd(1, 0, 8));
        emit(sd(5, 0, 16));
        emit(sd(1, 0, 24));
        emit(jal_w(0, 8));
        emit(sd(5, 0, 32));
        emit(alu_r(F3_ADD_SUB, f7_base_c, 7, 5, 5));
        emit(sd(7, 0, 40));
        reset_off();
        check_run("jal");

        for (int r = 0; r < 3; r++) begin
            reset_on();
            load_random();
            reset_off();
            check_run("random");
        end

        // reset in the middle of a program
        reset_on();
        prog_len = 0;
        emit(addi(1, 0, 11));
        emit(sd(1, 0, 0));
        emit(addi(2, 1, 22));
        emit(sd(2, 0, 8));
        emit(alu_r(F3_ADD_SUB, f7_base_c, 3, 2, 1));
        emit(sd(3, 0, 16));
        emit(alu_r(F3_ADD_SUB, f7_sub_c, 4, 3, 2));
        emit(sd(4, 0, 24));
        reset_off();
        wait_stores(1, done);
        if (!done) begin
            $display("mid_reset: no store before the second reset");
            errors++;
        end
        reset_on();
        reset_off();
        @(negedge clk);
        checks++;
        // fetch restarts at address zero
        if (if_inst_addr !== 64'h0) begin
            $display("FAIL mid_reset fetch address: expected %h, actual %h",
                     64'h0, if_inst_addr);
            errors++;
        end
        check_run("mid_reset");

        $display("tests %0d, store checks %0d, errors %0d", tests, checks, errors + wen_errs);
        if (errors + wen_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/core_cfg_pkg.sv
common/rv_isa_pkg.sv
fetch/inst_fetch.sv
decode/inst_decode.sv
verilog/reg_bypass.sv
execute/execute.sv
verilog/mem_wb.sv
verilog/core.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: rv64_pipe

sources:
  - common/core_cfg_pkg.sv
  - common/rv_isa_pkg.sv
  - fetch/inst_fetch.sv
  - decode/inst_decode.sv
  - verilog/reg_bypass.sv
  - execute/execute.sv
  - verilog/mem_wb.sv
  - verilog/core.sv
  - target: test
    files:
      - verification/core_tb.sv
